// ==== ara_pkg.sv ====
////////////////////////////////////////
// Vector accelerator shared definitions
// Sizes, opcodes, the instruction word and
// the host and queue payload formats
////////////////////////////////////////

package ara_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////

  localparam int unsigned NR_LANES       = 4;
  localparam int unsigned ELEMS_PER_LANE = 2;
  localparam int unsigned VLMAX          = NR_LANES * ELEMS_PER_LANE;
  localparam int unsigned NR_VREGS       = 8;
  localparam int unsigned ELEN           = 16;
  localparam int unsigned QUEUE_DEPTH    = 4;

  typedef logic [ELEN-1:0] elem_t;
  typedef logic [2:0]      vreg_idx_t;
  // Holds 0 up to VLMAX
  typedef logic [3:0]      vlen_t;

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////

  // Kinds 2 and 3 are illegal
  typedef enum logic [1:0] {
    KIND_CFG   = 2'd0,
    KIND_ARITH = 2'd1
  } kind_e;

  // Functs 6 and 7 are illegal
  typedef enum logic [2:0] {
    VOP_ADD    = 3'd0,
    VOP_SUB    = 3'd1,
    VOP_AND    = 3'd2,
    VOP_XOR    = 3'd3,
    VOP_MVX    = 3'd4,
    VOP_REDSUM = 3'd5
  } vop_e;

  // Set vector length
  typedef struct packed {
    kind_e       kind;
    logic [13:0] rsvd;
    logic [15:0] avl;
  } cfg_insn_t;

  // Element-wise arithmetic
  typedef struct packed {
    kind_e       kind;
    vop_e        funct;
    vreg_idx_t   vd;
    vreg_idx_t   vs1;
    vreg_idx_t   vs2;
    logic [17:0] rsvd;
  } arith_insn_t;

  typedef union packed {
    cfg_insn_t   cfg;
    arith_insn_t arith;
  } insn_u;

  ////////////////////////////////////////
  // Payloads
  ////////////////////////////////////////

  typedef struct packed {
    insn_u       insn;
    logic [31:0] rs1;
  } acc_req_t;

  typedef struct packed {
    logic [31:0] result;
    logic        error;
  } acc_resp_t;

  // One decoded operation as kept in the queue
  typedef struct packed {
    logic      is_cfg;
    logic      illegal;
    vop_e      op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    elem_t     scalar;
    vlen_t     vl;
  } vec_req_t;

endpackage

// ==== ara_dispatcher.sv ====
////////////////////////////////////////
// Vector dispatcher
// Decodes host instruction words, keeps the
// vector length and feeds the instruction queue
////////////////////////////////////////

`timescale 1ns/1ns

module ara_dispatcher (
  input  logic              clk_i,
  input  logic              rst_n_i,
  // Host request port
  input  ara_pkg::acc_req_t acc_req_i,
  input  logic              acc_req_valid_i,
  output logic              acc_req_ready_o,
  // Instruction queue
  input  logic              queue_full_i,
  output logic              queue_push_o,
  output ara_pkg::vec_req_t queue_req_o
);

  ara_pkg::vlen_t vl_q;
  ara_pkg::vlen_t cfg_vl;
  logic           accept;
  logic           kind_cfg;
  logic           kind_arith;
  logic           bad_funct;

  // One push per accepted host word
  assign acc_req_ready_o = !queue_full_i;
  assign accept          = acc_req_valid_i && acc_req_ready_o;
  assign queue_push_o    = accept;

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  assign kind_cfg   = (acc_req_i.insn.cfg.kind == ara_pkg::KIND_CFG);
  assign kind_arith = (acc_req_i.insn.arith.kind == ara_pkg::KIND_ARITH);
  assign bad_funct  = (acc_req_i.insn.arith.funct > ara_pkg::VOP_REDSUM);

  // Requested length clamped to VLMAX
  assign cfg_vl = (acc_req_i.insn.cfg.avl > 16'(ara_pkg::VLMAX)) ?
                  ara_pkg::vlen_t'(ara_pkg::VLMAX) :
                  ara_pkg::vlen_t'(acc_req_i.insn.cfg.avl);

  always_comb begin
    queue_req_o.is_cfg  = kind_cfg;
    queue_req_o.illegal = !(kind_cfg || kind_arith) || (kind_arith && bad_funct);
    queue_req_o.op      = acc_req_i.insn.arith.funct;
    queue_req_o.vd      = acc_req_i.insn.arith.vd;
    queue_req_o.vs1     = acc_req_i.insn.arith.vs1;
    queue_req_o.vs2     = acc_req_i.insn.arith.vs2;
    queue_req_o.scalar  = acc_req_i.rs1[ara_pkg::ELEN-1:0];
    // Config words carry the new length and arithmetic words the current one
    queue_req_o.vl      = kind_cfg ? cfg_vl : vl_q;
  end

  ////////////////////////////////////////
  // Vector length register
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vl_q <= ara_pkg::vlen_t'(ara_pkg::VLMAX);
    end else if (accept && kind_cfg) begin
      vl_q <= cfg_vl;
    end
  end

  // Queue never sees a push it has no room for
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    queue_push_o |-> !queue_full_i)
    else $error("[ara_dispatcher] push while the queue is full");

endmodule

// ==== ara_insn_queue.sv ====
////////////////////////////////////////
// Instruction queue
// Small circular FIFO of decoded operations
// between dispatcher and commit unit
////////////////////////////////////////

`timescale 1ns/1ns

module ara_insn_queue (
  input  logic              clk_i,
  input  logic              rst_n_i,
  // Write side
  input  logic              push_i,
  input  ara_pkg::vec_req_t push_req_i,
  output logic              full_o,
  // Read side
  input  logic              pop_i,
  output ara_pkg::vec_req_t head_o,
  output logic              valid_o
);

  typedef logic [$clog2(ara_pkg::QUEUE_DEPTH)-1:0] ptr_t;
  typedef logic [$clog2(ara_pkg::QUEUE_DEPTH):0]   cnt_t;

  ara_pkg::vec_req_t mem_q [ara_pkg::QUEUE_DEPTH];
  ptr_t              wr_ptr_q;
  ptr_t              rd_ptr_q;
  cnt_t              count_q;

  function automatic ptr_t ptr_inc(ptr_t p);
    return (p == ptr_t'(ara_pkg::QUEUE_DEPTH - 1)) ? '0 : p + ptr_t'(1);
  endfunction

  assign full_o  = (count_q == cnt_t'(ara_pkg::QUEUE_DEPTH));
  assign valid_o = (count_q != '0);
  assign head_o  = mem_q[rd_ptr_q];

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_req_i;
    end
  end

  // Pointers and fill level
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      if (push_i && !pop_i) begin
        count_q <= count_q + cnt_t'(1);
      end else if (pop_i && !push_i) begin
        count_q <= count_q - cnt_t'(1);
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i) push_i |-> !full_o)
    else $error("[ara_insn_queue] push into a full queue");

  assert property (@(posedge clk_i) disable iff (!rst_n_i) pop_i |-> valid_o)
    else $error("[ara_insn_queue] pop from an empty queue");

endmodule

// ==== ara_lane.sv ====
////////////////////////////////////////
// Vector lane
// Slice of the register file, element ALU
// and a partial sum for reductions
////////////////////////////////////////

`timescale 1ns/1ns

module ara_lane #(
  parameter int unsigned LANE_ID = 0
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              issue_i,
  input  ara_pkg::vec_req_t req_i,
  output ara_pkg::elem_t    partial_sum_o
);

  // Slot s holds element s * NR_LANES + LANE_ID
  ara_pkg::elem_t                      vrf_q [ara_pkg::NR_VREGS][ara_pkg::ELEMS_PER_LANE];
  ara_pkg::elem_t                      result [ara_pkg::ELEMS_PER_LANE];
  logic [ara_pkg::ELEMS_PER_LANE-1:0]  in_range;
  logic                                writes_vd;
  ara_pkg::elem_t                      sum_d;
  ara_pkg::elem_t                      sum_q;

  if (LANE_ID >= ara_pkg::NR_LANES) begin : gen_bad_id
    $error("[ara_lane] LANE_ID must be below NR_LANES");
  end

  assign writes_vd = !req_i.is_cfg && !req_i.illegal && (req_i.op != ara_pkg::VOP_REDSUM);

  ////////////////////////////////////////
  // Element ALU
  ////////////////////////////////////////

  always_comb begin
    sum_d = '0;
    for (int unsigned s = 0; s < ara_pkg::ELEMS_PER_LANE; s++) begin
      in_range[s] = (s * ara_pkg::NR_LANES + LANE_ID) < req_i.vl;
      case (req_i.op)
        ara_pkg::VOP_ADD: result[s] = vrf_q[req_i.vs1][s] + vrf_q[req_i.vs2][s];
        ara_pkg::VOP_SUB: result[s] = vrf_q[req_i.vs1][s] - vrf_q[req_i.vs2][s];
        ara_pkg::VOP_AND: result[s] = vrf_q[req_i.vs1][s] & vrf_q[req_i.vs2][s];
        ara_pkg::VOP_XOR: result[s] = vrf_q[req_i.vs1][s] ^ vrf_q[req_i.vs2][s];
        ara_pkg::VOP_MVX: result[s] = req_i.scalar;
        default:          result[s] = '0;
      endcase
      // Reduction only counts active elements
      if (in_range[s]) begin
        sum_d = sum_d + vrf_q[req_i.vs2][s];
      end
    end
  end

  ////////////////////////////////////////
  // Register slice and sum
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vrf_q <= '{default: '0};
      sum_q <= '0;
    end else if (issue_i) begin
      for (int unsigned s = 0; s < ara_pkg::ELEMS_PER_LANE; s++) begin
        // Tail elements keep their old value
        if (writes_vd && in_range[s]) begin
          vrf_q[req_i.vd][s] <= result[s];
        end
      end
      sum_q <= sum_d;
    end
  end

  assign partial_sum_o = sum_q;

endmodule

// ==== ara_commit_unit.sv ====
////////////////////////////////////////
// Commit unit
// Issues one operation at a time to the lanes
// and returns its response to the host in order
////////////////////////////////////////

`timescale 1ns/1ns

module ara_commit_unit (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  // Instruction queue
  input  ara_pkg::vec_req_t                       head_i,
  input  logic                                    head_valid_i,
  output logic                                    pop_o,
  // Lanes
  output logic                                    issue_o,
  input  ara_pkg::elem_t [ara_pkg::NR_LANES-1:0]  partial_sums_i,
  // Host response port
  output ara_pkg::acc_resp_t                      acc_resp_o,
  output logic                                    acc_resp_valid_o,
  input  logic                                    acc_resp_ready_i
);

  logic               inflight_q;
  ara_pkg::vec_req_t  op_q;
  ara_pkg::elem_t     red_sum;
  ara_pkg::acc_resp_t resp_d;
  ara_pkg::acc_resp_t resp_q;
  logic               resp_valid_q;

  // Wait for the lanes and for the host before the next issue
  assign issue_o = head_valid_i && !inflight_q && !resp_valid_q;
  assign pop_o   = issue_o;

  // Lane sums wrap at ELEN bits
  always_comb begin
    red_sum = '0;
    for (int unsigned l = 0; l < ara_pkg::NR_LANES; l++) begin
      red_sum = red_sum + partial_sums_i[l];
    end
  end

  always_comb begin
    resp_d = '0;
    if (op_q.illegal) begin
      resp_d.error = 1'b1;
    end else if (op_q.is_cfg) begin
      resp_d.result = 32'(op_q.vl);
    end else if (op_q.op == ara_pkg::VOP_REDSUM) begin
      resp_d.result = 32'(red_sum);
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      inflight_q   <= 1'b0;
      resp_valid_q <= 1'b0;
    end else begin
      inflight_q <= issue_o;
      if (inflight_q) begin
        resp_valid_q <= 1'b1;
      end else if (acc_resp_ready_i) begin
        resp_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_o) begin
      op_q <= head_i;
    end
    if (inflight_q) begin
      resp_q <= resp_d;
    end
  end

  assign acc_resp_o       = resp_q;
  assign acc_resp_valid_o = resp_valid_q;

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    acc_resp_valid_o && !acc_resp_ready_i |=> acc_resp_valid_o && $stable(acc_resp_o))
    else $error("[ara_commit_unit] response changed before the host took it");

endmodule

// ==== ara_top.sv ====
////////////////////////////////////////
// Vector accelerator top level
// Dispatcher, instruction queue, four lanes
// and commit unit behind the host ports
////////////////////////////////////////

`timescale 1ns/1ns

module ara_top (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // Host request port
  input  ara_pkg::acc_req_t  acc_req_i,
  input  logic               acc_req_valid_i,
  output logic               acc_req_ready_o,
  // Host response port
  output ara_pkg::acc_resp_t acc_resp_o,
  output logic               acc_resp_valid_o,
  input  logic               acc_resp_ready_i
);

  logic                                   queue_push;
  logic                                   queue_full;
  logic                                   queue_pop;
  logic                                   head_valid;
  logic                                   issue;
  ara_pkg::vec_req_t                      push_req;
  ara_pkg::vec_req_t                      head_req;
  ara_pkg::elem_t [ara_pkg::NR_LANES-1:0] partial_sums;

  ara_dispatcher i_dispatcher (
    .clk_i           (clk_i          ),
    .rst_n_i         (rst_n_i        ),
    .acc_req_i       (acc_req_i      ),
    .acc_req_valid_i (acc_req_valid_i),
    .acc_req_ready_o (acc_req_ready_o),
    .queue_full_i    (queue_full     ),
    .queue_push_o    (queue_push     ),
    .queue_req_o     (push_req       )
  );

  ara_insn_queue i_insn_queue (
    .clk_i      (clk_i     ),
    .rst_n_i    (rst_n_i   ),
    .push_i     (queue_push),
    .push_req_i (push_req  ),
    .full_o     (queue_full),
    .pop_i      (queue_pop ),
    .head_o     (head_req  ),
    .valid_o    (head_valid)
  );

  // All lanes see the same head operation
  for (genvar l = 0; l < ara_pkg::NR_LANES; l++) begin : gen_lanes
    ara_lane #(
      .LANE_ID (l)
    ) i_lane (
      .clk_i         (clk_i          ),
      .rst_n_i       (rst_n_i        ),
      .issue_i       (issue          ),
      .req_i         (head_req       ),
      .partial_sum_o (partial_sums[l])
    );
  end : gen_lanes

  ara_commit_unit i_commit_unit (
    .clk_i            (clk_i           ),
    .rst_n_i          (rst_n_i         ),
    .head_i           (head_req        ),
    .head_valid_i     (head_valid      ),
    .pop_o            (queue_pop       ),
    .issue_o          (issue           ),
    .partial_sums_i   (partial_sums    ),
    .acc_resp_o       (acc_resp_o      ),
    .acc_resp_valid_o (acc_resp_valid_o),
    .acc_resp_ready_i (acc_resp_ready_i)
  );

endmodule

// ==== tb_ara_top.sv ====
////////////////////////////////////////
// Vector accelerator testbench
// Drives host words, models the register
// file and checks every response in order
////////////////////////////////////////

`timescale 1ns/1ns

module tb_ara_top;

  localparam logic [31:0] SEED       = 32'he2f8_e5a9;
  localparam int unsigned WAIT_LIMIT = 2000;

  logic               clk_i;
  logic               rst_n_i;
  ara_pkg::acc_req_t  acc_req_i;
  logic               acc_req_valid_i;
  logic               acc_req_ready_o;
  ara_pkg::acc_resp_t acc_resp_o;
  logic               acc_resp_valid_o;
  logic               acc_resp_ready_i;

  // Model state and bookkeeping
  logic [ara_pkg::ELEN-1:0] model_vrf [ara_pkg::NR_VREGS][ara_pkg::VLMAX];
  int unsigned              model_vl;
  ara_pkg::acc_resp_t       expected [$];
  logic [31:0]              stim_state;
  logic [31:0]              bp_state;
  logic                     bp_on;
  logic                     saw_full;
  int unsigned              errors;

  ara_top dut (
    .clk_i            (clk_i           ),
    .rst_n_i          (rst_n_i         ),
    .acc_req_i        (acc_req_i       ),
    .acc_req_valid_i  (acc_req_valid_i ),
    .acc_req_ready_o  (acc_req_ready_o ),
    .acc_resp_o       (acc_resp_o      ),
    .acc_resp_valid_o (acc_resp_valid_o),
    .acc_resp_ready_i (acc_resp_ready_i)
  );

  always #4 clk_i = ~clk_i;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // Galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic lfsr_draw(inout logic [31:0] state, input int unsigned n,
                           output logic [31:0] val);
    val = '0;
    for (int unsigned b = 0; b < n; b++) begin
      state = lfsr_step(state);
      val   = {val[30:0], state[0]};
    end
  endtask

  function automatic logic [31:0] cfg_word(input logic [15:0] avl);
    return {2'b00, 14'h0, avl};
  endfunction

  function automatic logic [31:0] arith_word(input logic [2:0] funct, input logic [2:0] vd,
                                             input logic [2:0] vs1, input logic [2:0] vs2);
    return {2'b01, funct, vd, vs1, vs2, 18'h0};
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      stop_run("Stopping at the first mismatch");
    end
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function automatic ara_pkg::acc_resp_t model_response(input logic [31:0] insn,
                                                        input logic [31:0] rs1);
    ara_pkg::acc_resp_t       resp;
    logic [2:0]               funct;
    logic [2:0]               vd;
    logic [2:0]               vs1;
    logic [2:0]               vs2;
    logic [ara_pkg::ELEN-1:0] a;
    logic [ara_pkg::ELEN-1:0] b;
    logic [ara_pkg::ELEN-1:0] sum;
    resp  = '0;
    funct = insn[29:27];
    vd    = insn[26:24];
    vs1   = insn[23:21];
    vs2   = insn[20:18];
    sum   = '0;
    if (insn[31:30] == 2'd0) begin
      model_vl    = (insn[15:0] > 16'(ara_pkg::VLMAX)) ? ara_pkg::VLMAX : insn[15:0];
      resp.result = 32'(model_vl);
    end else if (insn[31:30] != 2'd1 || funct > 3'd5) begin
      resp.error = 1'b1;
    end else begin
      // Elements at or above vl are left alone
      for (int unsigned i = 0; i < model_vl; i++) begin
        a   = model_vrf[vs1][i];
        b   = model_vrf[vs2][i];
        sum = sum + b;
        case (funct)
          3'd0: model_vrf[vd][i] = a + b;
          3'd1: model_vrf[vd][i] = a - b;
          3'd2: model_vrf[vd][i] = a & b;
          3'd3: model_vrf[vd][i] = a ^ b;
          3'd4: model_vrf[vd][i] = rs1[ara_pkg::ELEN-1:0];
          default: ;
        endcase
      end
      if (funct == 3'd5) begin
        resp.result = 32'(sum);
      end
    end
    return resp;
  endfunction

  ////////////////////////////////////////
  // Host side
  ////////////////////////////////////////

  // Called 1 ns after a rising edge, returns at the same offset
  task automatic send_req(input logic [31:0] insn, input logic [31:0] rs1);
    int unsigned waited;
    waited          = 0;
    acc_req_i       = {insn, rs1};
    acc_req_valid_i = 1'b1;
    @(negedge clk_i);
    while (!acc_req_ready_o) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        stop_run("Timeout: the request was never accepted");
      end
      @(negedge clk_i);
    end
    expected.push_back(model_response(insn, rs1));
    @(posedge clk_i);
    #1;
    acc_req_valid_i = 1'b0;
  endtask

  task automatic wait_drain();
    int unsigned waited;
    waited = 0;
    while (expected.size() != 0) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        stop_run("Timeout: responses still outstanding after the last request");
      end
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic random_insn(output logic [31:0] insn, output logic [31:0] rs1);
    logic [31:0] sel;
    logic [31:0] bits;
    lfsr_draw(stim_state, 3, sel);
    lfsr_draw(stim_state, 32, bits);
    lfsr_draw(stim_state, 32, rs1);
    if (sel == 0) begin
      insn = {2'b00, bits[29:16], 11'h0, bits[4:0]};
    end else if (sel == 7) begin
      // Kind 2 or 3
      insn = {1'b1, bits[30:0]};
    end else begin
      insn = {2'b01, bits[29:0]};
    end
  endtask

  // Response back-pressure
  always @(posedge clk_i) begin : drive_ready
    logic [31:0] bits;
    #1;
    if (bp_on) begin
      lfsr_draw(bp_state, 1, bits);
      acc_resp_ready_i = bits[0];
    end else begin
      acc_resp_ready_i = 1'b1;
    end
  end

  // Compare each response transfer with the model
  always @(negedge clk_i) begin : check_responses
    ara_pkg::acc_resp_t exp_resp;
    if (rst_n_i && acc_resp_valid_o && acc_resp_ready_i) begin
      if (expected.size() == 0) begin
        stop_run("A response arrived with no request outstanding");
      end else begin
        exp_resp = expected.pop_front();
        check_value(64'(acc_resp_o), 64'(exp_resp), "response {result, error}");
      end
    end
    if (rst_n_i && acc_resp_valid_o && !acc_resp_ready_i && !acc_req_ready_o) begin
      saw_full = 1'b1;
    end
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin : run
    logic [31:0] insn;
    logic [31:0] rs1;
    clk_i            = 1'b0;
    rst_n_i          = 1'b0;
    acc_req_i        = '0;
    acc_req_valid_i  = 1'b0;
    acc_resp_ready_i = 1'b1;
    bp_on            = 1'b0;
    saw_full         = 1'b0;
    errors           = 0;
    stim_state       = SEED;
    bp_state         = ~SEED;
    model_vl         = ara_pkg::VLMAX;
    for (int r = 0; r < ara_pkg::NR_VREGS; r++) begin
      for (int i = 0; i < ara_pkg::VLMAX; i++) begin
        model_vrf[r][i] = '0;
      end
    end
    repeat (8) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    // Idle after reset, every register reads as zero
    check_value(64'(acc_resp_valid_o), 64'd0, "response valid after reset");
    check_value(64'(acc_req_ready_o), 64'd1, "request ready after reset");
    for (int r = 0; r < ara_pkg::NR_VREGS; r++) begin
      send_req(arith_word(3'd5, 3'd0, 3'd0, 3'(r)), 32'h0);
    end
    wait_drain();

    // Length clamping
    send_req(cfg_word(16'd0), 32'h0);
    send_req(cfg_word(16'd5), 32'h0);
    send_req(cfg_word(16'd8), 32'h0);
    send_req(cfg_word(16'd200), 32'h0);
    wait_drain();

    // Full-length arithmetic with 16-bit wrap
    send_req(arith_word(3'd4, 3'd1, 3'd0, 3'd0), 32'h1234_fff0);
    send_req(arith_word(3'd4, 3'd2, 3'd0, 3'd0), 32'habcd_0025);
    for (int op = 0; op < 4; op++) begin
      send_req(arith_word(3'(op), 3'(op + 3), 3'd1, 3'd2), 32'h0);
      send_req(arith_word(3'd5, 3'd0, 3'd0, 3'(op + 3)), 32'h0);
    end
    wait_drain();

    // Short length leaves the tail untouched
    send_req(cfg_word(16'd3), 32'h0);
    send_req(arith_word(3'd4, 3'd1, 3'd0, 3'd0), 32'h0000_0101);
    send_req(arith_word(3'd0, 3'd3, 3'd1, 3'd1), 32'h0);
    send_req(cfg_word(16'd8), 32'h0);
    send_req(arith_word(3'd5, 3'd0, 3'd0, 3'd1), 32'h0);
    send_req(arith_word(3'd5, 3'd0, 3'd0, 3'd3), 32'h0);
    wait_drain();

    // Illegal words change nothing
    send_req({2'd2, 14'h0, 16'd3}, 32'h5555);
    send_req({2'd3, 3'd4, 3'd1, 24'h0}, 32'h7777);
    send_req(arith_word(3'd6, 3'd2, 3'd1, 3'd1), 32'h0);
    send_req(arith_word(3'd7, 3'd3, 3'd2, 3'd2), 32'h0);
    for (int r = 1; r < 4; r++) begin
      send_req(arith_word(3'd5, 3'd0, 3'd0, 3'(r)), 32'h0);
    end
    wait_drain();

    // Random mix under back-pressure
    bp_on = 1'b1;
    repeat (300) begin
      random_insn(insn, rs1);
      send_req(insn, rs1);
    end
    bp_on = 1'b0;
    wait_drain();
    check_value(64'(saw_full), 64'd1, "request ready low while a response was held");

    if (errors == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      stop_run("Checks failed during the run");
    end
  end

endmodule

// ==== flist.f ====
ara_pkg.sv
ara_dispatcher.sv
ara_insn_queue.sv
ara_lane.sv
ara_commit_unit.sv
ara_top.sv
tb_ara_top.sv
